//--- logic/dcache_pkg.sv
package dcache_pkg;

    ////////////////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////////////////
    localparam int LINES          = 256;  // Direct mapped, one way
    localparam int LINE_BYTES     = 16;
    localparam int WORDS_PER_LINE = 4;    // Also the fill beat count
    localparam int INDEX_W        = 8;
    localparam int TAG_W          = 20;

    ////////////////////////////////////////////////////
    // Address and line views
    ////////////////////////////////////////////////////
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [1:0]         word;      // Word within line
        logic [1:0]         byte_off;  // Byte within word
    } addr_t;

    // One line, seen as words for fill and load select
    // and as bytes for the byte-enable merge
    typedef union packed {
        logic [WORDS_PER_LINE-1:0][31:0] words;
        logic [LINE_BYTES-1:0][7:0]      bytes;
    } line_u;

    // Processor request, 69 bits
    typedef struct packed {
        logic        write;   // 1 = store
        addr_t       addr;
        logic [31:0] wdata;
        logic [3:0]  strb;    // Store byte strobes
    } req_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WTHRU,
        FILL,
        TAGWR
    } state_e;

endpackage

//--- logic/dcache_data_ram.sv
`timescale 1ns/100ps

// Line store, simple dual port
// Byte-wide write columns, read address registered on clka
module dcache_data_ram (
    input  logic                               clka,
    input  logic [dcache_pkg::INDEX_W-1:0]     wr_index,  // Write line
    input  logic [dcache_pkg::INDEX_W-1:0]     rd_index,  // Read line, sampled on clka
    input  dcache_pkg::line_u                  dina,
    input  logic [dcache_pkg::LINE_BYTES-1:0]  wea,       // One enable per byte column
    output dcache_pkg::line_u                  doutb
);

    ////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////
    dcache_pkg::line_u                 lines [dcache_pkg::LINES];
    logic [dcache_pkg::INDEX_W-1:0]    rd_q;   // Registered read address

    // Byte column writes
    // All-zero wea means no write at all
    always_ff @(posedge clka) begin
        for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
            if (wea[b]) begin
                lines[wr_index].bytes[b] <= dina.bytes[b];
            end
        end
    end

    // Read address register
    always_ff @(posedge clka) begin
        rd_q <= rd_index;
    end

    ////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////
    // Array read after the address register
    // so a write on the same edge is visible next cycle
    assign doutb = lines[rd_q];

endmodule

//--- logic/dcache_tag_ram.sv
`timescale 1ns/100ps

// Tag store with per-line valid bits and the hit compare
module dcache_tag_ram (
    input  logic                            clka,
    input  logic                            rst,
    input  logic [dcache_pkg::INDEX_W-1:0]  rd_index,    // Sampled on clka
    input  logic [dcache_pkg::TAG_W-1:0]    lookup_tag,  // Compared one cycle after rd_index
    input  logic                            wr_en,
    input  logic [dcache_pkg::INDEX_W-1:0]  wr_index,
    input  logic [dcache_pkg::TAG_W-1:0]    wr_tag,
    output logic                            hit
);

    ////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////
    logic [dcache_pkg::TAG_W-1:0]    tags [dcache_pkg::LINES];
    logic [dcache_pkg::LINES-1:0]    valid;   // One bit per line
    logic [dcache_pkg::INDEX_W-1:0]  rd_q;

    // Tag array write
    always_ff @(posedge clka) begin
        if (wr_en) begin
            tags[wr_index] <= wr_tag;
        end
    end

    // Valid vector, empty cache after reset
    always_ff @(posedge clka) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_index] <= 1'b1;  // Line now filled
        end
    end

    always_ff @(posedge clka) begin
        rd_q <= rd_index;  // Same read timing as the line store
    end

    ////////////////////////////////////////////////////
    // Hit compare
    ////////////////////////////////////////////////////
    assign hit = valid[rd_q] && (tags[rd_q] == lookup_tag);

endmodule

//--- logic/dcache_beat_counter.sv
`timescale 1ns/100ps

// Fill beat counter
// Counts returned words of one line read
module dcache_beat_counter (
    input  logic       clka,
    input  logic       rst,
    input  logic       clear,    // Restart at fill start
    input  logic       beat_in,  // One accepted beat
    output logic [1:0] beat,     // Word slot of the arriving beat
    output logic       last      // Final beat arriving now
);

    logic [1:0] cnt;

    always_ff @(posedge clka) begin
        if (rst) begin
            cnt <= '0;
        end else if (clear) begin
            cnt <= '0;
        end else if (beat_in) begin
            cnt <= cnt + 2'd1;  // Wraps after word 3
        end
    end

    assign beat = cnt;

    // Only during a beat on the top slot
    assign last = beat_in && (cnt == 2'(dcache_pkg::WORDS_PER_LINE - 1));

endmodule

//--- logic/dcache_line_merge.sv
`timescale 1ns/100ps

// Write data and byte enables for the line store
// plus the load word select, all combinational
module dcache_line_merge (
    input  logic                               fill_wr,    // Fill beat this cycle
    input  logic                               store_wr,   // Store hit this cycle
    input  logic [1:0]                         beat,       // Fill word slot
    input  logic [31:0]                        mem_rdata,
    input  dcache_pkg::req_t                   req,        // Latched request
    input  dcache_pkg::line_u                  line_in,    // Line store read data
    output dcache_pkg::line_u                  dina,
    output logic [dcache_pkg::LINE_BYTES-1:0]  wea,
    output logic [31:0]                        word_out
);

    ////////////////////////////////////////////////////
    // Source select
    ////////////////////////////////////////////////////
    logic [1:0]  slot;      // Target word in line
    logic [31:0] data_sel;  // Word to place
    logic [3:0]  byte_en;   // Enables within that word

    always_comb begin
        slot     = req.addr.word;
        data_sel = req.wdata;
        byte_en  = '0;
        if (fill_wr) begin
            slot     = beat;
            data_sel = mem_rdata;
            byte_en  = 4'hf;       // Whole word from memory
        end else if (store_wr) begin
            byte_en  = req.strb;   // Only strobed bytes
        end
    end

    ////////////////////////////////////////////////////
    // Byte lane build
    ////////////////////////////////////////////////////
    // Word copied to every slot, wea picks the live bytes
    always_comb begin
        for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
            dina.bytes[b] = data_sel[(b % 4) * 8 +: 8];
            wea[b]        = ((b / 4) == int'(slot)) && byte_en[b % 4];
        end
    end

    // Load word by latched offset
    assign word_out = line_in.words[req.addr.word];

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/100ps

// Cache controller
// IDLE, LOOKUP, then WTHRU for stores or FILL and TAGWR for load misses
module dcache_ctrl (
    input  logic                            clka,
    input  logic                            rst,
    input  logic                            cpu_req,
    input  dcache_pkg::req_t                cpu_in,
    input  logic                            hit,         // From tag store, valid in LOOKUP
    input  logic                            mem_rvalid,
    input  logic                            last,        // Final fill beat
    output dcache_pkg::req_t                cur_req,
    output logic [dcache_pkg::INDEX_W-1:0]  rd_index,
    output logic                            tag_wr,
    output logic                            fill_wr,
    output logic                            store_wr,
    output logic                            cnt_clear,
    output logic                            cpu_busy,
    output logic                            cpu_done,
    output logic                            mem_rd_req,
    output logic                            mem_wr,
    output logic [31:0]                     mem_addr
);

    dcache_pkg::state_e state;
    dcache_pkg::state_e state_nx;
    dcache_pkg::req_t   cur_q;
    logic               accept;   // Request taken this cycle

    assign accept = cpu_req && !cpu_busy;

    ////////////////////////////////////////////////////
    // Request latch and state
    ////////////////////////////////////////////////////
    always_ff @(posedge clka) begin
        if (accept) begin
            cur_q <= cpu_in;
        end
    end

    always_ff @(posedge clka) begin
        if (rst) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            dcache_pkg::IDLE: begin
                if (accept) state_nx = dcache_pkg::LOOKUP;
            end
            dcache_pkg::LOOKUP: begin
                if (cur_q.write)  state_nx = dcache_pkg::WTHRU;  // Store, hit or not
                else if (hit)     state_nx = dcache_pkg::IDLE;   // Load hit done
                else              state_nx = dcache_pkg::FILL;   // Load miss
            end
            dcache_pkg::WTHRU: state_nx = dcache_pkg::IDLE;
            dcache_pkg::FILL: begin
                if (mem_rvalid && last) state_nx = dcache_pkg::TAGWR;
            end
            dcache_pkg::TAGWR: state_nx = dcache_pkg::LOOKUP;   // Replay, now hits
            default:           state_nx = dcache_pkg::IDLE;
        endcase
    end

    ////////////////////////////////////////////////////
    // Registered pulses
    ////////////////////////////////////////////////////
    always_ff @(posedge clka) begin
        if (rst) begin
            cpu_done   <= 1'b0;
            mem_rd_req <= 1'b0;
        end else begin
            // Cycle after LOOKUP for stores and load hits
            cpu_done   <= (state == dcache_pkg::LOOKUP) && (cur_q.write || hit);
            mem_rd_req <= (state == dcache_pkg::LOOKUP) && !cur_q.write && !hit;
        end
    end

    ////////////////////////////////////////////////////
    // Decoded outputs
    ////////////////////////////////////////////////////
    assign cur_req   = cur_q;
    assign cpu_busy  = (state != dcache_pkg::IDLE) || cpu_done;  // Held through done
    assign tag_wr    = (state == dcache_pkg::TAGWR);
    assign fill_wr   = (state == dcache_pkg::FILL) && mem_rvalid;
    assign store_wr  = (state == dcache_pkg::WTHRU) && hit;  // Index held since LOOKUP
    assign cnt_clear = (state == dcache_pkg::LOOKUP);
    assign mem_wr    = (state == dcache_pkg::WTHRU);

    // New index straight from the request so LOOKUP sees its line
    assign rd_index = (state == dcache_pkg::IDLE) ? cpu_in.addr.index : cur_q.addr.index;

    // Word address for stores, line address for fills
    assign mem_addr = cur_q.write ? {cur_q.addr.tag, cur_q.addr.index, cur_q.addr.word, 2'b00}
                                  : {cur_q.addr.tag, cur_q.addr.index, 4'b0000};

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/100ps

// Direct-mapped write-through data cache
module dcache_top (
    input  logic              clka,
    input  logic              rst,
    // Processor side
    input  logic              cpu_req,
    input  dcache_pkg::req_t  cpu_in,
    output logic              cpu_busy,
    output logic              cpu_done,
    output logic [31:0]       cpu_rdata,
    // Memory side
    output logic              mem_rd_req,
    output logic              mem_wr,
    output logic [31:0]       mem_addr,
    output logic [31:0]       mem_wdata,
    output logic [3:0]        mem_wstrb,
    input  logic              mem_rvalid,
    input  logic [31:0]       mem_rdata
);

    dcache_pkg::req_t                    cur_req;
    logic [dcache_pkg::INDEX_W-1:0]      rd_index;
    logic                                hit;
    logic                                tag_wr;
    logic                                fill_wr;
    logic                                store_wr;
    logic                                cnt_clear;
    logic [1:0]                          beat;
    logic                                last;
    dcache_pkg::line_u                   dina;
    dcache_pkg::line_u                   doutb;
    logic [dcache_pkg::LINE_BYTES-1:0]   wea;

    ////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////
    dcache_ctrl i_ctrl (
        .clka, .rst, .cpu_req, .cpu_in, .hit, .mem_rvalid, .last,
        .cur_req, .rd_index, .tag_wr, .fill_wr, .store_wr, .cnt_clear,
        .cpu_busy, .cpu_done, .mem_rd_req, .mem_wr, .mem_addr
    );

    dcache_beat_counter i_beat_counter (
        .clka, .rst, .clear(cnt_clear), .beat_in(mem_rvalid), .beat, .last
    );

    ////////////////////////////////////////////////////
    // Stores and merge
    ////////////////////////////////////////////////////
    dcache_tag_ram i_tag_ram (
        .clka, .rst, .rd_index, .lookup_tag(cur_req.addr.tag), .wr_en(tag_wr),
        .wr_index(cur_req.addr.index), .wr_tag(cur_req.addr.tag), .hit
    );

    dcache_data_ram i_data_ram (
        .clka, .wr_index(cur_req.addr.index), .rd_index, .dina, .wea, .doutb
    );

    dcache_line_merge i_line_merge (
        .fill_wr, .store_wr, .beat, .mem_rdata, .req(cur_req), .line_in(doutb),
        .dina, .wea, .word_out(cpu_rdata)
    );

    // Write-through data straight from the latched store
    assign mem_wdata = cur_req.wdata;
    assign mem_wstrb = cur_req.strb;

endmodule

//--- dv/dcache_props.sv
`timescale 1ns/100ps

// Controller properties, bound into dcache_ctrl
module dcache_props (
    input logic                clka,
    input logic                rst,
    input dcache_pkg::state_e  state,
    input logic                hit,
    input logic                cpu_busy,
    input logic                cpu_done,
    input logic                mem_rd_req,
    input logic                mem_wr
);

    int fail_cnt = 0;  // Failed assertion tally

    ////////////////////////////////////////////////////
    // Pulse and ordering rules
    ////////////////////////////////////////////////////
    done_pulse: assert property (@(posedge clka) disable iff (rst)
        cpu_done |=> !cpu_done)
        else begin
            $error("cpu_done stayed high for more than one cycle");
            fail_cnt++;
        end

    rd_wr_apart: assert property (@(posedge clka) disable iff (rst)
        !(mem_rd_req && mem_wr))
        else begin
            $error("mem_rd_req and mem_wr high together");
            fail_cnt++;
        end

    // Read request is registered, so it follows a missing LOOKUP
    rd_after_miss: assert property (@(posedge clka) disable iff (rst)
        mem_rd_req |-> ($past(state) == dcache_pkg::LOOKUP) && !$past(hit))
        else begin
            $error("mem_rd_req without a missing lookup");
            fail_cnt++;
        end

    idle_after_reset: assert property (@(posedge clka)
        $fell(rst) |-> !cpu_busy)
        else begin
            $error("cpu_busy high right after reset release");
            fail_cnt++;
        end

endmodule

bind dcache_ctrl dcache_props i_props (
    .clka, .rst, .state, .hit, .cpu_busy, .cpu_done, .mem_rd_req, .mem_wr
);

//--- dv/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

    localparam int NUM_REQ    = 400;
    localparam int WAIT_LIMIT = 200;  // Negedges per request before giving up

    logic              clka;
    logic              rst;
    logic              cpu_req;
    dcache_pkg::req_t  cpu_in;
    logic              cpu_busy;
    logic              cpu_done;
    logic [31:0]       cpu_rdata;
    logic              mem_rd_req;
    logic              mem_wr;
    logic [31:0]       mem_addr;
    logic [31:0]       mem_wdata;
    logic [3:0]        mem_wstrb;
    logic              mem_rvalid;
    logic [31:0]       mem_rdata;

    logic [31:0] lcg_state = 32'h0b2f5517;
    logic [31:0] mem_model [4096];    // 16 KB window, word array
    logic [19:0] tag_model [256];     // Cache model, one tag per index
    logic        valid_model [256];
    logic        timed_out = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          loads = 0;
    int          stores = 0;
    int          fills = 0;

    dcache_top i_dcache_top (
        .clka, .rst, .cpu_req, .cpu_in, .cpu_busy, .cpu_done, .cpu_rdata,
        .mem_rd_req, .mem_wr, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rvalid, .mem_rdata
    );

    initial begin
        clka = 1'b0;
        forever #50 clka = ~clka;  // 100 ns period
    end

    ////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // Four beats in word order, 0 to 3 idle cycles before each
    task automatic send_line(input logic [31:0] addr);
        int gap;
        for (int b = 0; b < 4; b++) begin
            gap = int'(next_rand() >> 30);
            repeat (gap) begin
                @(posedge clka);
                mem_rvalid <= 1'b0;
            end
            @(posedge clka);
            mem_rvalid <= 1'b1;
            mem_rdata  <= mem_model[{addr[13:4], 2'(b)}];
        end
        @(posedge clka);
        mem_rvalid <= 1'b0;
    endtask

    task automatic run_request(input logic is_wr, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb);
        dcache_pkg::req_t req;
        logic             exp_miss;
        logic             saw_rd;
        logic             saw_wr;
        logic             done;
        int               cycles;
        req.write = is_wr;
        req.addr  = addr;
        req.wdata = wdata;
        req.strb  = strb;
        exp_miss  = !valid_model[addr[11:4]] || (tag_model[addr[11:4]] != addr[31:12]);
        saw_rd    = 1'b0;
        saw_wr    = 1'b0;
        done      = 1'b0;
        cycles    = 0;
        @(posedge clka);
        cpu_req <= 1'b1;
        cpu_in  <= req;
        @(posedge clka);
        cpu_req <= 1'b0;  // Single-cycle request
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge clka);
            cycles++;
            check_val("cpu_busy", 1'b1, cpu_busy);
            if (mem_wr) begin
                saw_wr = 1'b1;
                check_val("mem_addr", addr, mem_addr);
                check_val("mem_wdata", wdata, mem_wdata);
                check_val("mem_wstrb", strb, mem_wstrb);
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) begin
                        mem_model[addr[13:2]][b*8 +: 8] = wdata[b*8 +: 8];
                    end
                end
            end
            if (cpu_done) begin
                done = 1'b1;
            end else if (mem_rd_req) begin
                saw_rd = 1'b1;
                check_val("mem_addr", {addr[31:4], 4'h0}, mem_addr);  // Line aligned
                send_line(addr);
            end
        end
        if (!done) begin
            $display("Timeout: no cpu_done within %0d cycles for request at %h",
                     WAIT_LIMIT, addr);
            errors++;
            timed_out = 1'b1;
        end else begin
            check_val("mem_rd_req", !is_wr && exp_miss, saw_rd);
            check_val("mem_wr", is_wr, saw_wr);
            if (is_wr || !exp_miss) begin
                check_val("cpu_done latency", 2, cycles);
            end
            if (is_wr) begin
                stores++;
            end else begin
                loads++;
                check_val("cpu_rdata", mem_model[addr[13:2]], cpu_rdata);
            end
            if (!is_wr && exp_miss) begin
                fills++;
                valid_model[addr[11:4]] = 1'b1;  // Fill allocates the line
                tag_model[addr[11:4]]   = addr[31:12];
            end
        end
    endtask

    ////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////
    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] prev;
        logic [31:0] wdata;
        logic        is_wr;
        int          total;
        rst        = 1'b1;
        cpu_req    = 1'b0;
        cpu_in     = '0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        prev       = '0;
        for (int i = 0; i < 4096; i++) begin
            mem_model[i] = next_rand();
        end
        for (int i = 0; i < 256; i++) begin
            valid_model[i] = 1'b0;
            tag_model[i]   = '0;
        end
        repeat (5) @(posedge clka);
        rst <= 1'b0;
        @(negedge clka);
        check_val("cpu_busy", 1'b0, cpu_busy);  // Idle before first request
        for (int n = 0; n < NUM_REQ && !timed_out; n++) begin
            r     = next_rand();
            is_wr = ((r >> 24) % 10) < 4;      // About 40% stores
            r     = next_rand();
            if (r[31]) begin
                addr = {prev[31:4], r[29:28], 2'b00};  // Same line again
            end else begin
                addr = {18'd0, r[27:16], 2'b00};       // Anywhere in 16 KB
            end
            wdata = next_rand();
            r     = next_rand();
            run_request(is_wr, addr, wdata, r[31:28]);
            prev  = addr;
        end
        total = errors + i_dcache_top.i_ctrl.i_props.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d, loads %0d, stores %0d, fills %0d",
                 checks, errors, i_dcache_top.i_ctrl.i_props.fail_cnt, loads, stores, fills);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
logic/dcache_pkg.sv
logic/dcache_data_ram.sv
logic/dcache_tag_ram.sv
logic/dcache_beat_counter.sv
logic/dcache_line_merge.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/dcache_props.sv
dv/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  # Cache RTL, package first
  - target: rtl
    files:
      - logic/dcache_pkg.sv
      - logic/dcache_data_ram.sv
      - logic/dcache_tag_ram.sv
      - logic/dcache_beat_counter.sv
      - logic/dcache_line_merge.sv
      - logic/dcache_ctrl.sv
      - logic/dcache_top.sv

  # Testbench and bound properties
  - target: test
    files:
      - dv/dcache_props.sv
      - dv/dcache_tb.sv
